//--- source/smartnic_app_macros.svh
`ifndef SMARTNIC_APP_MACROS_SVH
`define SMARTNIC_APP_MACROS_SVH

// Processing ports and host queues
`define SMARTNIC_NUM_PROC_PORTS 2
`define SMARTNIC_NUM_HOST_IFS   3

// Queue id wide enough for every host queue
`define SMARTNIC_QID_W $clog2(`SMARTNIC_NUM_HOST_IFS)

// Stream payload width
`define SMARTNIC_DATA_W 64

`endif

//--- source/smartnic_pkg.sv
`include "smartnic_app_macros.svh"

package smartnic_pkg;

    // Stream payload and host queue tag
    typedef logic [`SMARTNIC_DATA_W-1:0] data_t;
    typedef logic [`SMARTNIC_QID_W-1:0]  qid_t;

    // Steering decision per packet
    typedef enum logic [1:0] {
        ROUTE_NET  = 2'd0,
        ROUTE_HOST = 2'd1,
        ROUTE_LOOP = 2'd2,
        ROUTE_DROP = 2'd3
    } route_t;

    // Which input a packet entered on
    typedef enum logic {
        SRC_NET  = 1'b0,
        SRC_HOST = 1'b1
    } src_t;

endpackage

//--- source/smartnic_reg_pkg.sv
package smartnic_reg_pkg;

    // Register data and counter widths
    typedef logic [15:0] reg_data_t;
    typedef logic [15:0] cnt_t;

    // Route word is {qid, route} in bits 3:0
    typedef enum logic [3:0] {
        REG_ROUTE_P0    = 4'h0,
        REG_ROUTE_P1    = 4'h1,
        REG_PKT_CNT_P0  = 4'h4,
        REG_PKT_CNT_P1  = 4'h5,
        REG_DROP_CNT_P0 = 4'h8,
        REG_DROP_CNT_P1 = 4'h9
    } reg_addr_t;

endpackage

//--- source/smartnic_ingress_mux.sv
`timescale 1ns/1ps
`include "smartnic_app_macros.svh"

module smartnic_ingress_mux (
    input  logic                 clk,
    input  logic                 arst_n,
    input  smartnic_pkg::data_t  net_in_tdata  [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                 net_in_tvalid [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                 net_in_tlast  [`SMARTNIC_NUM_PROC_PORTS],
    output logic                 net_in_tready [`SMARTNIC_NUM_PROC_PORTS],
    input  smartnic_pkg::data_t  h2c_tdata     [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                 h2c_tvalid    [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                 h2c_tlast     [`SMARTNIC_NUM_PROC_PORTS],
    input  smartnic_pkg::qid_t   h2c_tqid      [`SMARTNIC_NUM_PROC_PORTS],
    output logic                 h2c_tready    [`SMARTNIC_NUM_PROC_PORTS],
    output smartnic_pkg::data_t  mux_tdata     [`SMARTNIC_NUM_PROC_PORTS],
    output logic                 mux_tvalid    [`SMARTNIC_NUM_PROC_PORTS],
    output logic                 mux_tlast     [`SMARTNIC_NUM_PROC_PORTS],
    output smartnic_pkg::qid_t   mux_tqid      [`SMARTNIC_NUM_PROC_PORTS],
    output smartnic_pkg::src_t   mux_tsrc      [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                 mux_tready    [`SMARTNIC_NUM_PROC_PORTS]
);

    for (genvar i = 0; i < `SMARTNIC_NUM_PROC_PORTS; i++) begin : g_port
        smartnic_pkg::src_t grant_q;
        smartnic_pkg::src_t sel;
        logic               busy_q;
        logic               host_sel;

        // ==================================================================
        // Grant selection
        // ==================================================================
        always_comb begin
            if (busy_q) begin
                sel = grant_q;
            end else if (net_in_tvalid[i] && h2c_tvalid[i]) begin
                // Both waiting, serve the one not served last
                sel = (grant_q == smartnic_pkg::SRC_NET) ? smartnic_pkg::SRC_HOST
                                                         : smartnic_pkg::SRC_NET;
            end else if (h2c_tvalid[i]) begin
                sel = smartnic_pkg::SRC_HOST;
            end else begin
                sel = smartnic_pkg::SRC_NET;
            end
        end

        // Held from first beat to last beat
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                grant_q <= smartnic_pkg::SRC_NET;
                busy_q  <= 1'b0;
            end else if (mux_tvalid[i] && mux_tready[i]) begin
                grant_q <= sel;
                busy_q  <= !mux_tlast[i];
            end
        end

        assign host_sel = (sel == smartnic_pkg::SRC_HOST);

        // Datapath
        assign mux_tdata[i]     = host_sel ? h2c_tdata[i]  : net_in_tdata[i];
        assign mux_tvalid[i]    = host_sel ? h2c_tvalid[i] : net_in_tvalid[i];
        assign mux_tlast[i]     = host_sel ? h2c_tlast[i]  : net_in_tlast[i];
        assign mux_tqid[i]      = host_sel ? h2c_tqid[i]   : '0;
        assign mux_tsrc[i]      = sel;
        assign net_in_tready[i] = !host_sel && mux_tready[i];
        assign h2c_tready[i]    = host_sel && mux_tready[i];

        // No source switch inside a packet
        a_grant_held : assert property (@(posedge clk) disable iff (!arst_n)
            mux_tvalid[i] && mux_tready[i] && !mux_tlast[i]
            |=> mux_tsrc[i] == $past(mux_tsrc[i]));
    end

endmodule

//--- source/smartnic_port_proc.sv
`timescale 1ns/1ps
`include "smartnic_app_macros.svh"

module smartnic_port_proc (
    input  logic                      clk,
    input  logic                      arst_n,
    input  smartnic_pkg::data_t       in_tdata,
    input  logic                      in_tvalid,
    input  logic                      in_tlast,
    input  smartnic_pkg::qid_t        in_tqid,
    input  smartnic_pkg::src_t        in_tsrc,
    output logic                      in_tready,
    input  smartnic_pkg::route_t      cfg_route,
    input  smartnic_pkg::qid_t        cfg_qid,
    output smartnic_pkg::data_t       out_tdata,
    output logic                      out_tvalid,
    output logic                      out_tlast,
    output smartnic_pkg::qid_t        out_tqid,
    output smartnic_pkg::src_t        out_tsrc,
    output smartnic_pkg::route_t      out_troute,
    input  logic                      out_tready,
    output smartnic_reg_pkg::cnt_t    pkt_cnt,
    output smartnic_reg_pkg::cnt_t    drop_cnt
);

    smartnic_pkg::route_t route_q;
    smartnic_pkg::route_t cur_route;
    smartnic_pkg::qid_t   hqid_q;
    smartnic_pkg::qid_t   cur_qid;
    logic                 in_pkt_q;
    logic                 drop;
    logic                 accept;

    // ======================================================================
    // Route decision, sampled at the first beat
    // ======================================================================
    assign cur_route = in_pkt_q ? route_q : cfg_route;
    assign cur_qid   = in_pkt_q ? hqid_q  : cfg_qid;
    assign drop      = (cur_route == smartnic_pkg::ROUTE_DROP);

    // Dropped beats are swallowed without waiting on the output
    assign in_tready = drop || !out_tvalid || out_tready;
    assign accept    = in_tvalid && in_tready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_pkt_q <= 1'b0;
            route_q  <= smartnic_pkg::ROUTE_NET;
        end else if (accept) begin
            in_pkt_q <= !in_tlast;
            route_q  <= cur_route;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hqid_q <= cur_qid;
        end
    end

    // ======================================================================
    // Output stage
    // ======================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_tvalid <= 1'b0;
        end else if (accept && !drop) begin
            out_tvalid <= 1'b1;
        end else if (out_tready) begin
            out_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !drop) begin
            out_tdata  <= in_tdata;
            out_tlast  <= in_tlast;
            out_tsrc   <= in_tsrc;
            out_troute <= cur_route;
            // Host route retags the queue, loopback keeps the original
            out_tqid   <= (cur_route == smartnic_pkg::ROUTE_HOST) ? cur_qid : in_tqid;
        end
    end

    // Packet and drop counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_cnt  <= '0;
            drop_cnt <= '0;
        end else begin
            if (out_tvalid && out_tready && out_tlast) begin
                pkt_cnt <= pkt_cnt + 1'b1;
            end
            if (accept && drop && in_tlast) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

    // Held beat stays put until taken
    a_out_hold : assert property (@(posedge clk) disable iff (!arst_n)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata));

endmodule

//--- source/smartnic_egress_demux.sv
`timescale 1ns/1ps
`include "smartnic_app_macros.svh"

module smartnic_egress_demux (
    input  smartnic_pkg::data_t   proc_tdata     [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                  proc_tvalid    [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                  proc_tlast     [`SMARTNIC_NUM_PROC_PORTS],
    input  smartnic_pkg::qid_t    proc_tqid      [`SMARTNIC_NUM_PROC_PORTS],
    input  smartnic_pkg::src_t    proc_tsrc      [`SMARTNIC_NUM_PROC_PORTS],
    input  smartnic_pkg::route_t  proc_troute    [`SMARTNIC_NUM_PROC_PORTS],
    output logic                  proc_tready    [`SMARTNIC_NUM_PROC_PORTS],
    output smartnic_pkg::data_t   net_out_tdata  [`SMARTNIC_NUM_PROC_PORTS],
    output logic                  net_out_tvalid [`SMARTNIC_NUM_PROC_PORTS],
    output logic                  net_out_tlast  [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                  net_out_tready [`SMARTNIC_NUM_PROC_PORTS],
    output smartnic_pkg::data_t   c2h_tdata      [`SMARTNIC_NUM_PROC_PORTS],
    output logic                  c2h_tvalid     [`SMARTNIC_NUM_PROC_PORTS],
    output logic                  c2h_tlast      [`SMARTNIC_NUM_PROC_PORTS],
    output smartnic_pkg::qid_t    c2h_tqid       [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                  c2h_tready     [`SMARTNIC_NUM_PROC_PORTS]
);

    for (genvar i = 0; i < `SMARTNIC_NUM_PROC_PORTS; i++) begin : g_port
        logic to_c2h;

        // Loopback returns toward the source; drops never reach this stage
        always_comb begin
            case (proc_troute[i])
                smartnic_pkg::ROUTE_HOST: to_c2h = 1'b1;
                smartnic_pkg::ROUTE_LOOP: to_c2h = (proc_tsrc[i] == smartnic_pkg::SRC_HOST);
                default:                  to_c2h = 1'b0;
            endcase
        end

        // Network side
        assign net_out_tdata[i]  = proc_tdata[i];
        assign net_out_tlast[i]  = proc_tlast[i];
        assign net_out_tvalid[i] = proc_tvalid[i] && !to_c2h;

        // Host side
        assign c2h_tdata[i]      = proc_tdata[i];
        assign c2h_tlast[i]      = proc_tlast[i];
        assign c2h_tqid[i]       = proc_tqid[i];
        assign c2h_tvalid[i]     = proc_tvalid[i] && to_c2h;

        // Ready from the chosen side only
        assign proc_tready[i]    = to_c2h ? c2h_tready[i] : net_out_tready[i];
    end

endmodule

//--- source/smartnic_app_regs.sv
`timescale 1ns/1ps
`include "smartnic_app_macros.svh"

module smartnic_app_regs (
    input  logic                                             clk,
    input  logic                                             arst_n,
    input  logic                                             reg_wr,
    input  logic                                             reg_rd,
    input  logic [$bits(smartnic_reg_pkg::reg_addr_t)-1:0]   reg_addr,
    input  smartnic_reg_pkg::reg_data_t                      reg_wdata,
    output smartnic_reg_pkg::reg_data_t                      reg_rdata,
    output logic                                             reg_rvalid,
    input  smartnic_reg_pkg::cnt_t   pkt_cnt   [`SMARTNIC_NUM_PROC_PORTS],
    input  smartnic_reg_pkg::cnt_t   drop_cnt  [`SMARTNIC_NUM_PROC_PORTS],
    output smartnic_pkg::route_t     cfg_route [`SMARTNIC_NUM_PROC_PORTS],
    output smartnic_pkg::qid_t       cfg_qid   [`SMARTNIC_NUM_PROC_PORTS]
);

    smartnic_reg_pkg::reg_data_t rd_mux;

    // Route writes, bits 1:0 route and 3:2 queue id
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < `SMARTNIC_NUM_PROC_PORTS; p++) begin
                cfg_route[p] <= smartnic_pkg::ROUTE_NET;
                cfg_qid[p]   <= '0;
            end
        end else if (reg_wr) begin
            case (reg_addr)
                smartnic_reg_pkg::REG_ROUTE_P0: begin
                    cfg_route[0] <= smartnic_pkg::route_t'(reg_wdata[1:0]);
                    cfg_qid[0]   <= reg_wdata[3:2];
                end
                smartnic_reg_pkg::REG_ROUTE_P1: begin
                    cfg_route[1] <= smartnic_pkg::route_t'(reg_wdata[1:0]);
                    cfg_qid[1]   <= reg_wdata[3:2];
                end
                default: ;
            endcase
        end
    end

    // Read decode, unknown addresses read as zero
    always_comb begin
        case (reg_addr)
            smartnic_reg_pkg::REG_ROUTE_P0:
                rd_mux = smartnic_reg_pkg::reg_data_t'({cfg_qid[0], cfg_route[0]});
            smartnic_reg_pkg::REG_ROUTE_P1:
                rd_mux = smartnic_reg_pkg::reg_data_t'({cfg_qid[1], cfg_route[1]});
            smartnic_reg_pkg::REG_PKT_CNT_P0:  rd_mux = pkt_cnt[0];
            smartnic_reg_pkg::REG_PKT_CNT_P1:  rd_mux = pkt_cnt[1];
            smartnic_reg_pkg::REG_DROP_CNT_P0: rd_mux = drop_cnt[0];
            smartnic_reg_pkg::REG_DROP_CNT_P1: rd_mux = drop_cnt[1];
            default:                           rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

//--- source/smartnic_app_core.sv
`timescale 1ns/1ps
`include "smartnic_app_macros.svh"

module smartnic_app_core (
    input  logic                                           clk,
    input  logic                                           arst_n,
    input  smartnic_pkg::data_t  net_in_tdata   [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                 net_in_tvalid  [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                 net_in_tlast   [`SMARTNIC_NUM_PROC_PORTS],
    output logic                 net_in_tready  [`SMARTNIC_NUM_PROC_PORTS],
    input  smartnic_pkg::data_t  h2c_tdata      [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                 h2c_tvalid     [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                 h2c_tlast      [`SMARTNIC_NUM_PROC_PORTS],
    input  smartnic_pkg::qid_t   h2c_tqid       [`SMARTNIC_NUM_PROC_PORTS],
    output logic                 h2c_tready     [`SMARTNIC_NUM_PROC_PORTS],
    output smartnic_pkg::data_t  net_out_tdata  [`SMARTNIC_NUM_PROC_PORTS],
    output logic                 net_out_tvalid [`SMARTNIC_NUM_PROC_PORTS],
    output logic                 net_out_tlast  [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                 net_out_tready [`SMARTNIC_NUM_PROC_PORTS],
    output smartnic_pkg::data_t  c2h_tdata      [`SMARTNIC_NUM_PROC_PORTS],
    output logic                 c2h_tvalid     [`SMARTNIC_NUM_PROC_PORTS],
    output logic                 c2h_tlast      [`SMARTNIC_NUM_PROC_PORTS],
    output smartnic_pkg::qid_t   c2h_tqid       [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                 c2h_tready     [`SMARTNIC_NUM_PROC_PORTS],
    input  logic                                           reg_wr,
    input  logic                                           reg_rd,
    input  logic [$bits(smartnic_reg_pkg::reg_addr_t)-1:0] reg_addr,
    input  smartnic_reg_pkg::reg_data_t                    reg_wdata,
    output smartnic_reg_pkg::reg_data_t                    reg_rdata,
    output logic                                           reg_rvalid
);

    // ======================================================================
    // Inter-stage streams and configuration
    // ======================================================================
    smartnic_pkg::data_t     mux_tdata   [`SMARTNIC_NUM_PROC_PORTS];
    logic                    mux_tvalid  [`SMARTNIC_NUM_PROC_PORTS];
    logic                    mux_tlast   [`SMARTNIC_NUM_PROC_PORTS];
    smartnic_pkg::qid_t      mux_tqid    [`SMARTNIC_NUM_PROC_PORTS];
    smartnic_pkg::src_t      mux_tsrc    [`SMARTNIC_NUM_PROC_PORTS];
    logic                    mux_tready  [`SMARTNIC_NUM_PROC_PORTS];
    smartnic_pkg::data_t     proc_tdata  [`SMARTNIC_NUM_PROC_PORTS];
    logic                    proc_tvalid [`SMARTNIC_NUM_PROC_PORTS];
    logic                    proc_tlast  [`SMARTNIC_NUM_PROC_PORTS];
    smartnic_pkg::qid_t      proc_tqid   [`SMARTNIC_NUM_PROC_PORTS];
    smartnic_pkg::src_t      proc_tsrc   [`SMARTNIC_NUM_PROC_PORTS];
    smartnic_pkg::route_t    proc_troute [`SMARTNIC_NUM_PROC_PORTS];
    logic                    proc_tready [`SMARTNIC_NUM_PROC_PORTS];
    smartnic_pkg::route_t    cfg_route   [`SMARTNIC_NUM_PROC_PORTS];
    smartnic_pkg::qid_t      cfg_qid     [`SMARTNIC_NUM_PROC_PORTS];
    smartnic_reg_pkg::cnt_t  pkt_cnt     [`SMARTNIC_NUM_PROC_PORTS];
    smartnic_reg_pkg::cnt_t  drop_cnt    [`SMARTNIC_NUM_PROC_PORTS];

    smartnic_ingress_mux u_mux (.*);

    // One processor per port
    for (genvar i = 0; i < `SMARTNIC_NUM_PROC_PORTS; i++) begin : g_proc
        smartnic_port_proc u_proc (
            .clk        (clk),
            .arst_n     (arst_n),
            .in_tdata   (mux_tdata[i]),
            .in_tvalid  (mux_tvalid[i]),
            .in_tlast   (mux_tlast[i]),
            .in_tqid    (mux_tqid[i]),
            .in_tsrc    (mux_tsrc[i]),
            .in_tready  (mux_tready[i]),
            .cfg_route  (cfg_route[i]),
            .cfg_qid    (cfg_qid[i]),
            .out_tdata  (proc_tdata[i]),
            .out_tvalid (proc_tvalid[i]),
            .out_tlast  (proc_tlast[i]),
            .out_tqid   (proc_tqid[i]),
            .out_tsrc   (proc_tsrc[i]),
            .out_troute (proc_troute[i]),
            .out_tready (proc_tready[i]),
            .pkt_cnt    (pkt_cnt[i]),
            .drop_cnt   (drop_cnt[i])
        );
    end

    smartnic_egress_demux u_demux (.*);

    smartnic_app_regs u_regs (.*);

endmodule

//--- dv/tb_smartnic_model.svh
`ifndef TB_SMARTNIC_MODEL_SVH
`define TB_SMARTNIC_MODEL_SVH

// Expected beat as {qid, last, data}
typedef logic [66:0] beat_t;

// One queue per port, output and source
beat_t exp_q [`SMARTNIC_NUM_PROC_PORTS*4][$];

// Mirror of the route registers and expected counts
smartnic_pkg::route_t model_route [`SMARTNIC_NUM_PROC_PORTS];
smartnic_pkg::qid_t   model_qid   [`SMARTNIC_NUM_PROC_PORTS];
int                   model_pkts  [`SMARTNIC_NUM_PROC_PORTS];
int                   model_drops [`SMARTNIC_NUM_PROC_PORTS];

// Output 0 is net_out, 1 is c2h; source 0 is network, 1 is host
function automatic int queue_index(input int p, input int o, input int s);
    return p * 4 + o * 2 + s;
endfunction

// Destination 2 means the packet is dropped
function automatic int predict_dest(input int p, input int s);
    case (model_route[p])
        smartnic_pkg::ROUTE_NET:  return 0;
        smartnic_pkg::ROUTE_HOST: return 1;
        smartnic_pkg::ROUTE_LOOP: return s;
        default:                  return 2;
    endcase
endfunction

// Qid seen on the output, zero where the output carries none
function automatic smartnic_pkg::qid_t predict_qid(input int p, input int s,
                                                   input smartnic_pkg::qid_t in_qid);
    case (model_route[p])
        smartnic_pkg::ROUTE_HOST: return model_qid[p];
        smartnic_pkg::ROUTE_LOOP: return (s == 1) ? in_qid : '0;
        default:                  return '0;
    endcase
endfunction

function automatic void expect_packet(input int p, input int s,
                                      input smartnic_pkg::qid_t in_qid,
                                      input smartnic_pkg::data_t beats [4], input int len);
    int dest;
    smartnic_pkg::qid_t q;
    dest = predict_dest(p, s);
    q = predict_qid(p, s, in_qid);
    if (dest == 2) begin
        model_drops[p]++;
    end else begin
        model_pkts[p]++;
        for (int b = 0; b < len; b++) begin
            exp_q[queue_index(p, dest, s)].push_back({q, b == len - 1, beats[b]});
        end
    end
endfunction

function automatic int pending();
    int n;
    n = 0;
    for (int i = 0; i < `SMARTNIC_NUM_PROC_PORTS * 4; i++) begin
        n += exp_q[i].size();
    end
    return n;
endfunction

`endif

//--- dv/tb_smartnic_app.sv
`timescale 1ns/1ps
`include "smartnic_app_macros.svh"

module tb_smartnic_app;

    localparam int NP           = `SMARTNIC_NUM_PROC_PORTS;
    localparam int PKTS_PER_SRC = 10;
    localparam int NUM_PHASES   = 4;
    // Every packet of every phase at 4 beats and 20 cycles per beat
    localparam int TIMEOUT_NS   = NUM_PHASES * NP * 2 * PKTS_PER_SRC * 4 * 20 * 10;

    logic                        clk = 1'b0;
    logic                        arst_n;
    smartnic_pkg::data_t         net_in_tdata   [NP];
    logic                        net_in_tvalid  [NP];
    logic                        net_in_tlast   [NP];
    logic                        net_in_tready  [NP];
    smartnic_pkg::data_t         h2c_tdata      [NP];
    logic                        h2c_tvalid     [NP];
    logic                        h2c_tlast      [NP];
    smartnic_pkg::qid_t          h2c_tqid       [NP];
    logic                        h2c_tready     [NP];
    smartnic_pkg::data_t         net_out_tdata  [NP];
    logic                        net_out_tvalid [NP];
    logic                        net_out_tlast  [NP];
    logic                        net_out_tready [NP];
    smartnic_pkg::data_t         c2h_tdata      [NP];
    logic                        c2h_tvalid     [NP];
    logic                        c2h_tlast      [NP];
    smartnic_pkg::qid_t          c2h_tqid       [NP];
    logic                        c2h_tready     [NP];
    logic                        reg_wr;
    logic                        reg_rd;
    logic [3:0]                  reg_addr;
    smartnic_reg_pkg::reg_data_t reg_wdata;
    smartnic_reg_pkg::reg_data_t reg_rdata;
    logic                        reg_rvalid;

    logic [15:0] lfsr = 16'd44;
    string       test_name = "reset";
    logic        open_pkt [NP*2];
    logic        open_src [NP*2];

    `include "tb_smartnic_model.svh"

    smartnic_app_core dut0 (.*);

    always #5 clk = ~clk;

    // Fibonacci taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic compare(input string label, input beat_t expected, input beat_t actual);
        if (expected !== actual) begin
            $display("Fail %s %s expected %h actual %h", test_name, label, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // ======================================================================
    // Register access
    // ======================================================================
    task automatic write_reg(input logic [3:0] addr, input smartnic_reg_pkg::reg_data_t data);
        @(negedge clk);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr    = 1'b0;
    endtask

    // Read data returns one cycle after the strobe as a single pulse
    task automatic read_reg(input logic [3:0] addr, output smartnic_reg_pkg::reg_data_t data);
        @(negedge clk);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd   = 1'b0;
        compare("rvalid", 1, reg_rvalid);
        data = reg_rdata;
        @(negedge clk);
        compare("rvalid pulse end", 0, reg_rvalid);
    endtask

    task automatic set_route(input int p, input smartnic_pkg::route_t r,
                             input smartnic_pkg::qid_t q);
        write_reg(p ? smartnic_reg_pkg::REG_ROUTE_P1 : smartnic_reg_pkg::REG_ROUTE_P0,
                  {12'd0, q, r});
        model_route[p] = r;
        model_qid[p]   = q;
    endtask

    // ======================================================================
    // Stream drivers and output monitor
    // ======================================================================
    task automatic drive_beat(input int p, input int s, input logic v,
                              input smartnic_pkg::data_t d, input logic l,
                              input smartnic_pkg::qid_t q);
        if (s == 1) begin
            h2c_tvalid[p] = v;
            h2c_tdata[p]  = d;
            h2c_tlast[p]  = l;
            h2c_tqid[p]   = q;
        end else begin
            net_in_tvalid[p] = v;
            net_in_tdata[p]  = d;
            net_in_tlast[p]  = l;
        end
    endtask

    // Data carries source, port, packet and beat number for tracing
    task automatic send_stream(input int p, input int s);
        smartnic_pkg::data_t beats [4];
        smartnic_pkg::qid_t  qid;
        int                  len;
        for (int n = 0; n < PKTS_PER_SRC; n++) begin
            len = rand_bits(2) + 1;
            qid = (s == 1) ? smartnic_pkg::qid_t'(rand_bits(2) % 3) : '0;
            for (int b = 0; b < len; b++) begin
                beats[b] = {s[0], p[0], 14'(n), 16'(b), rand_bits(32)};
            end
            expect_packet(p, s, qid, beats, len);
            for (int b = 0; b < len; b++) begin
                while (rand_bits(2) == 0) begin
                    @(negedge clk);
                end
                drive_beat(p, s, 1'b1, beats[b], b == len - 1, qid);
                @(posedge clk);
                while (!((s == 1) ? h2c_tready[p] : net_in_tready[p])) begin
                    @(posedge clk);
                end
                @(negedge clk);
                drive_beat(p, s, 1'b0, '0, 1'b0, '0);
            end
        end
    endtask

    task automatic take_beat(input int p, input int o, input smartnic_pkg::data_t d,
                             input logic l, input smartnic_pkg::qid_t q);
        int    s;
        int    k;
        beat_t e;
        s = d[63];
        k = p * 2 + o;
        if (exp_q[queue_index(p, o, s)].size() == 0) begin
            $display("Unexpected beat on port %0d %s output during %s",
                     p, (o == 1) ? "c2h" : "net", test_name);
            $display("Test failed");
            $fatal(1);
        end else begin
            e = exp_q[queue_index(p, o, s)].pop_front();
            compare("beat", e, {q, l, d});
            if (open_pkt[k]) begin
                compare("packet interleave", beat_t'(open_src[k]), beat_t'(s));
            end
            open_pkt[k] = !l;
            open_src[k] = s[0];
        end
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            for (int p = 0; p < NP; p++) begin
                if (net_out_tvalid[p] && net_out_tready[p]) begin
                    take_beat(p, 0, net_out_tdata[p], net_out_tlast[p], '0);
                end
                if (c2h_tvalid[p] && c2h_tready[p]) begin
                    take_beat(p, 1, c2h_tdata[p], c2h_tlast[p], c2h_tqid[p]);
                end
            end
        end
    end

    // Output back-pressure with ready about three cycles in four
    always @(negedge clk) begin
        for (int p = 0; p < NP; p++) begin
            net_out_tready[p] = (rand_bits(2) != 0);
            c2h_tready[p]     = (rand_bits(2) != 0);
        end
    end

    task automatic run_phase(input string name);
        test_name = name;
        fork
            send_stream(0, 0);
            send_stream(0, 1);
            send_stream(1, 0);
            send_stream(1, 1);
        join
        while (pending() != 0) begin
            @(negedge clk);
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin : stimulus
        smartnic_reg_pkg::reg_data_t rd;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        for (int p = 0; p < NP; p++) begin
            drive_beat(p, 0, 1'b0, '0, 1'b0, '0);
            drive_beat(p, 1, 1'b0, '0, 1'b0, '0);
            net_out_tready[p] = 1'b0;
            c2h_tready[p]     = 1'b0;
            model_route[p]    = smartnic_pkg::ROUTE_NET;
            model_qid[p]      = '0;
            model_pkts[p]     = 0;
            model_drops[p]    = 0;
        end
        for (int k = 0; k < NP * 2; k++) begin
            open_pkt[k] = 1'b0;
            open_src[k] = 1'b0;
        end
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        run_phase("route_net");
        set_route(0, smartnic_pkg::ROUTE_HOST, 2);
        set_route(1, smartnic_pkg::ROUTE_HOST, 1);
        run_phase("route_host");
        // Qid 3 is never a source qid, so a wrong retag shows up
        set_route(0, smartnic_pkg::ROUTE_LOOP, 3);
        set_route(1, smartnic_pkg::ROUTE_LOOP, 3);
        run_phase("route_loop");
        set_route(0, smartnic_pkg::ROUTE_DROP, 0);
        set_route(1, smartnic_pkg::ROUTE_NET, 0);
        run_phase("route_drop");

        test_name = "counters";
        for (int p = 0; p < NP; p++) begin
            read_reg(p ? smartnic_reg_pkg::REG_PKT_CNT_P1 : smartnic_reg_pkg::REG_PKT_CNT_P0, rd);
            compare($sformatf("pkt_cnt port %0d", p), beat_t'(model_pkts[p]), beat_t'(rd));
            read_reg(p ? smartnic_reg_pkg::REG_DROP_CNT_P1 : smartnic_reg_pkg::REG_DROP_CNT_P0,
                     rd);
            compare($sformatf("drop_cnt port %0d", p), beat_t'(model_drops[p]), beat_t'(rd));
        end

        test_name = "unknown_addr";
        read_reg(4'hf, rd);
        compare("rdata", '0, beat_t'(rd));

        $display("Test completed successfully");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout while waiting for traffic to drain in %s", test_name);
        $display("Test failed");
        $fatal(1);
    end

endmodule

//--- filelist.f
+incdir+source
+incdir+dv
source/smartnic_pkg.sv
source/smartnic_reg_pkg.sv
source/smartnic_ingress_mux.sv
source/smartnic_port_proc.sv
source/smartnic_egress_demux.sv
source/smartnic_app_regs.sv
source/smartnic_app_core.sv
dv/tb_smartnic_app.sv
